/* hw/snd_pkg.sv */
package snd_pkg;

    // sound CPU memory map, decoded from wb_adr[15:12]
    //   0000-3fff  banked program ROM
    //   4xxx       tone generator, a0 = wb_adr[0]
    //   7xxx       shared port
    //   8000-9fff  work RAM
    //   c000-ffff  ROM bank 0 on reads, control registers on writes
    typedef enum logic [2:0] {
        region_rom,
        region_tone,
        region_shared,
        region_ram,
        region_ctrl,
        region_none
    } snd_region_e;

    // control register offsets, selected by wb_adr[13:12]
    localparam logic [1:0] CTRL_BANK_OFS = 2'd0;  // c000, bank in data[6:4]
    localparam logic [1:0] CTRL_IRQ_OFS  = 2'd2;  // e000, frame irq ack

    // banked ROM
    localparam int ROM_BANK_BITS = 3;
    localparam int ROM_ADDR_BITS = 17;
    localparam int ROM_OFS_BITS  = ROM_ADDR_BITS - ROM_BANK_BITS;

    // tone generator register addresses
    typedef enum logic [7:0] {
        tone_key    = 8'h00,  // bit 0 left on, bit 1 right on
        tone_level  = 8'h01,  // signed amplitude
        tone_period = 8'h02   // half period in sample ticks, 0 = constant
    } tone_reg_e;

    // audio timing and scaling
    localparam int SAMPLE_DIV  = 64;  // clk cycles per sample tick
    localparam int LEVEL_SHIFT = 7;

    // mixer gains, 4.4 fixed point
    localparam logic [7:0] FM_GAIN   = 8'h10;
    localparam logic [7:0] PCM_GAIN  = 8'h10;
    localparam int         GAIN_FRAC = 4;

endpackage

/* hw/snd_bus_decode.sv */
`timescale 1ns/10ps

module snd_bus_decode (
    input  logic        clk,
    input  logic        srst_n,
    // wishbone slave
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [15:0] wb_adr,
    input  logic [ 7:0] wb_dat_w,
    output logic [ 7:0] wb_dat_r,
    output logic        wb_ack,
    // frame interrupt
    input  logic        lvbl,
    output logic        irq_n,
    // program ROM
    output logic        rom_cs,
    output logic [16:0] rom_addr,
    output logic        bus_busy,
    input  logic [ 7:0] rom_data,
    input  logic        rom_ok,
    // work RAM
    output logic        ram_we,
    input  logic [ 7:0] ram_dout,
    // shared port
    output logic        shared_cs,
    input  logic [ 7:0] shared_dout,
    // tone chip
    output logic        tone_cs,
    input  logic [ 7:0] tone_dout
);

    snd_pkg::snd_region_e region;

    logic [snd_pkg::ROM_BANK_BITS-1:0] bank;
    logic       req;       // new access pending this cycle
    logic       rom_hit;   // ROM data ready
    logic       lvbl_l;
    logic       high_win;
    logic [7:0] rd_mux;

    assign req      = wb_cyc & wb_stb & ~wb_ack;
    assign rom_hit  = rom_cs & rom_ok;
    assign high_win = &wb_adr[15:14];

    always_comb begin
        casez (wb_adr[15:12])
            4'b00??: region = snd_pkg::region_rom;
            4'b0100: region = snd_pkg::region_tone;
            4'b0111: region = snd_pkg::region_shared;
            4'b100?: region = snd_pkg::region_ram;
            4'b11??: region = wb_we ? snd_pkg::region_ctrl : snd_pkg::region_rom;
            default: region = snd_pkg::region_none;
        endcase
    end

    // high window always reads bank 0
    assign rom_addr = {high_win ? {snd_pkg::ROM_BANK_BITS{1'b0}} : bank,
                       wb_adr[snd_pkg::ROM_OFS_BITS-1:0]};
    assign bus_busy = rom_cs & ~rom_ok;

    assign ram_we    = req & wb_we & (region == snd_pkg::region_ram);
    assign shared_cs = req & (region == snd_pkg::region_shared);
    assign tone_cs   = req & (region == snd_pkg::region_tone);

    always_comb begin
        case (region)
            snd_pkg::region_tone:   rd_mux = tone_dout;
            snd_pkg::region_shared: rd_mux = shared_dout;
            snd_pkg::region_ram:    rd_mux = ram_dout;
            default:                rd_mux = 8'd0;  // ctrl and unmapped
        endcase
    end

    // read data lands together with wb_ack
    always_ff @(posedge clk) begin
        if (rom_hit) begin
            wb_dat_r <= rom_data;
        end else if (req && region != snd_pkg::region_rom) begin
            wb_dat_r <= rd_mux;
        end
    end

    always_ff @(posedge clk or negedge srst_n) begin
        if (!srst_n) begin
            wb_ack <= 1'b0;
            rom_cs <= 1'b0;
        end else begin
            wb_ack <= rom_hit | (req & (region != snd_pkg::region_rom));
            if (rom_hit) begin
                rom_cs <= 1'b0;
            end else if (req && region == snd_pkg::region_rom) begin
                rom_cs <= 1'b1;  // held until rom_ok
            end
        end
    end

    // bank register and frame irq latch
    always_ff @(posedge clk or negedge srst_n) begin
        if (!srst_n) begin
            bank   <= '0;
            irq_n  <= 1'b1;
            lvbl_l <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            if (req && region == snd_pkg::region_ctrl) begin
                if (wb_adr[13:12] == snd_pkg::CTRL_BANK_OFS) bank <= wb_dat_w[6:4];
                if (wb_adr[13:12] == snd_pkg::CTRL_IRQ_OFS) irq_n <= 1'b1;
            end
            if (!lvbl && lvbl_l) irq_n <= 1'b0;  // a new frame wins over the ack
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (!srst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held for two cycles");

    a_rom_cs_stb: assert property (@(posedge clk) disable iff (!srst_n)
        $rose(rom_cs) |-> wb_stb)
        else $error("rom_cs rose without wb_stb");

endmodule

/* hw/snd_tone_gen.sv */
`timescale 1ns/10ps

module snd_tone_gen (
    input  logic               clk,
    input  logic               srst_n,
    // register port
    input  logic               cs,
    input  logic               we,
    input  logic               a0,
    input  logic        [ 7:0] din,
    output logic        [ 7:0] dout,
    // audio
    output logic               sample,
    output logic signed [15:0] fm_l,
    output logic signed [15:0] fm_r
);

    localparam int DIV_W = $clog2(snd_pkg::SAMPLE_DIV);

    snd_pkg::tone_reg_e reg_sel;

    logic        [1:0]       key;
    logic signed [7:0]       level;
    logic        [7:0]       period;
    logic        [DIV_W-1:0] div_cnt;
    logic        [7:0]       half_cnt;
    logic                    pol;      // 1 = negative half
    logic signed [15:0]      amp;
    logic signed [15:0]      wave;

    assign dout = {6'd0, key};

    // register writes, address phase then data phase
    always_ff @(posedge clk or negedge srst_n) begin
        if (!srst_n) begin
            reg_sel <= snd_pkg::tone_key;
            key     <= 2'd0;
            level   <= 8'sd0;
            period  <= 8'd0;
        end else if (cs && we) begin
            if (!a0) begin
                reg_sel <= snd_pkg::tone_reg_e'(din);
            end else begin
                case (reg_sel)
                    snd_pkg::tone_key:    key    <= din[1:0];
                    snd_pkg::tone_level:  level  <= din;
                    snd_pkg::tone_period: period <= din;
                    default: ;  // unknown address, ignored
                endcase
            end
        end
    end

    // sample tick divider
    always_ff @(posedge clk or negedge srst_n) begin
        if (!srst_n) begin
            div_cnt <= '0;
            sample  <= 1'b0;
        end else begin
            sample  <= (div_cnt == DIV_W'(snd_pkg::SAMPLE_DIV - 1));
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign amp  = 16'(level) <<< snd_pkg::LEVEL_SHIFT;  // sign kept by extension
    assign wave = pol ? -amp : amp;

    always_ff @(posedge clk or negedge srst_n) begin
        if (!srst_n) begin
            half_cnt <= 8'd0;
            pol      <= 1'b0;
            fm_l     <= 16'sd0;
            fm_r     <= 16'sd0;
        end else if (sample) begin
            if (period == 8'd0) begin
                half_cnt <= 8'd0;
                pol      <= 1'b0;  // constant level
            end else if (half_cnt >= period - 8'd1) begin
                half_cnt <= 8'd0;
                pol      <= ~pol;
            end else begin
                half_cnt <= half_cnt + 8'd1;
            end
            fm_l <= key[0] ? wave : 16'sd0;
            fm_r <= key[1] ? wave : 16'sd0;
        end
    end

endmodule

/* hw/snd_mixer.sv */
`timescale 1ns/10ps

module snd_mixer (
    input  logic               clk,
    input  logic               srst_n,
    input  logic signed [15:0] fm,
    input  logic signed [10:0] pcm,
    output logic signed [15:0] mixed,
    output logic               peak
);

    // gains as positive signed factors
    localparam logic signed [8:0] FM_G  = {1'b0, snd_pkg::FM_GAIN};
    localparam logic signed [8:0] PCM_G = {1'b0, snd_pkg::PCM_GAIN};

    logic signed [24:0] fm_prod;
    logic signed [19:0] pcm_prod;
    logic signed [25:0] sum;
    logic signed [21:0] scaled;
    logic signed [15:0] clamped;
    logic               clip;

    assign fm_prod  = fm * FM_G;
    assign pcm_prod = pcm * PCM_G;
    assign sum      = fm_prod + pcm_prod;
    assign scaled   = sum[25:snd_pkg::GAIN_FRAC];  // arithmetic shift, 4.4 gain

    always_comb begin
        clip    = 1'b1;
        if (scaled > 22'sd32767) begin
            clamped = 16'sh7fff;
        end else if (scaled < -22'sd32768) begin
            clamped = 16'sh8000;
        end else begin
            clamped = scaled[15:0];
            clip    = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge srst_n) begin
        if (!srst_n) begin
            mixed <= 16'sd0;
            peak  <= 1'b0;
        end else begin
            mixed <= clamped;
            peak  <= clip;
        end
    end

    // without clipping the output is the plain scaled sum
    a_no_clip_exact: assert property (@(posedge clk) disable iff (!srst_n)
        ($past(srst_n) && !peak) |-> (mixed == $past(scaled)))
        else $error("mixer output differs from unclamped sum");

endmodule

/* hw/snd_top.sv */
`timescale 1ns/10ps

module snd_top (
    input  logic               clk,
    input  logic               srst_n,
    // wishbone slave
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic        [15:0] wb_adr,
    input  logic        [ 7:0] wb_dat_w,
    output logic        [ 7:0] wb_dat_r,
    output logic               wb_ack,
    // video timing
    input  logic               lvbl,
    output logic               irq_n,
    // program ROM
    output logic               rom_cs,
    output logic        [16:0] rom_addr,
    input  logic        [ 7:0] rom_data,
    input  logic               rom_ok,
    output logic               bus_busy,
    // work RAM and shared port
    output logic               ram_we,
    input  logic        [ 7:0] ram_dout,
    output logic               shared_cs,
    input  logic        [ 7:0] shared_dout,
    // audio
    input  logic signed [10:0] pcm_snd,
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic               sample,
    output logic               peak
);

    logic               tone_cs;
    logic        [ 7:0] tone_dout;
    logic signed [15:0] fm_l, fm_r;
    logic               peak_l, peak_r;

    assign peak = peak_l | peak_r;

    snd_bus_decode u_dec (
        .clk        (clk),
        .srst_n     (srst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .lvbl       (lvbl),
        .irq_n      (irq_n),
        .rom_cs     (rom_cs),
        .rom_addr   (rom_addr),
        .bus_busy   (bus_busy),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .ram_we     (ram_we),
        .ram_dout   (ram_dout),
        .shared_cs  (shared_cs),
        .shared_dout(shared_dout),
        .tone_cs    (tone_cs),
        .tone_dout  (tone_dout)
    );

    snd_tone_gen u_tone (
        .clk   (clk),
        .srst_n(srst_n),
        .cs    (tone_cs),
        .we    (wb_we),
        .a0    (wb_adr[0]),  // address/data select
        .din   (wb_dat_w),
        .dout  (tone_dout),
        .sample(sample),
        .fm_l  (fm_l),
        .fm_r  (fm_r)
    );

    snd_mixer u_left (
        .clk   (clk),
        .srst_n(srst_n),
        .fm    (fm_l),
        .pcm   (pcm_snd),
        .mixed (left),
        .peak  (peak_l)
    );

    snd_mixer u_right (
        .clk   (clk),
        .srst_n(srst_n),
        .fm    (fm_r),
        .pcm   (pcm_snd),  // same PCM stream on both sides
        .mixed (right),
        .peak  (peak_r)
    );

endmodule

/* dv/snd_tb.sv */
`timescale 1ns/10ps

module snd_tb;

    localparam int MAX_CASES = 64;

    typedef enum logic [2:0] {rd, wr, vbl, irqchk, mix} op_e;

    logic               clk;
    logic               srst_n;
    logic               wb_cyc, wb_stb, wb_we;
    logic        [15:0] wb_adr;
    logic        [ 7:0] wb_dat_w, wb_dat_r;
    logic               wb_ack;
    logic               lvbl, irq_n;
    logic               rom_cs, bus_busy;
    logic        [16:0] rom_addr;
    logic        [ 7:0] rom_data, ram_dout, shared_dout;
    logic               rom_ok = 1'b0;
    logic               ram_we, shared_cs;
    logic signed [10:0] pcm_snd;
    logic signed [15:0] left, right;
    logic               sample, peak;

    // case table from the data file
    logic [8*24-1:0] c_name [MAX_CASES];
    op_e             c_op   [MAX_CASES];
    logic [15:0]     c_adr  [MAX_CASES];
    logic [ 7:0]     c_dat  [MAX_CASES];
    logic [10:0]     c_pcm  [MAX_CASES];
    logic [15:0]     c_exp  [MAX_CASES];

    int   n_cases, n_pass, n_fail, errors;
    int   seed;
    int   rom_wait;
    int   ram_we_cnt = 0;
    int   shared_cnt = 0;
    int   busy_cnt   = 0;
    int   rom_stalls = 0;   // cycles the ROM model held rom_ok low
    int   since_sample;
    logic cases_loaded = 1'b0;
    logic [snd_pkg::ROM_BANK_BITS-1:0] cur_bank;  // bank the DUT should hold
    logic [7:0] ram_mem [0:8191];

    initial clk = 1'b0;
    always #5 clk = ~clk;

    snd_top dut (.*);

    assign rom_data    = rom_addr[7:0] ^ {5'd0, rom_addr[16:14]};  // low byte mixed with bank
    assign shared_dout = 8'h96;
    assign ram_dout    = ram_mem[wb_adr[12:0]];

    always @(posedge clk) begin
        if (ram_we) begin
            ram_mem[wb_adr[12:0]] <= wb_dat_w;
            ram_we_cnt <= ram_we_cnt + 1;
        end
    end

    // shared select and ROM stall seen at each edge
    always @(posedge clk) begin
        if (shared_cs) shared_cnt <= shared_cnt + 1;
        if (bus_busy) busy_cnt <= busy_cnt + 1;
    end

    // sample ticks one clk wide, SAMPLE_DIV clocks apart
    always @(posedge clk) begin
        if (!srst_n) begin
            since_sample <= -1;
        end else if (sample) begin
            if (since_sample >= 0 && since_sample != snd_pkg::SAMPLE_DIV - 1) begin
                $display("sample pulse came %0d clocks after the previous one, not %0d",
                         since_sample + 1, snd_pkg::SAMPLE_DIV);
                errors++;
            end
            since_sample <= 0;
        end else if (since_sample >= 0) begin
            since_sample <= since_sample + 1;
        end
    end

    // ROM answers after 0 to 3 extra cycles
    always @(posedge clk) begin
        #1;
        if (!rom_cs) begin
            rom_ok   = 1'b0;
            rom_wait = $random(seed) & 3;
        end else if (rom_wait == 0) begin
            rom_ok = 1'b1;
        end else begin
            rom_wait = rom_wait - 1;
            rom_stalls++;
        end
    end

    initial begin
        wait (cases_loaded);
        repeat (16 + n_cases * (snd_pkg::SAMPLE_DIV * 4 + 50)) @(posedge clk);
        $display("timeout: the cases did not finish within their cycle budget");
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_byte(input logic [8*24-1:0] name, input logic [7:0] exp,
                              input logic [7:0] act);
        if (act !== exp) begin
            $display("mismatch %0s expected %02h actual %02h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input logic [8*24-1:0] name, input logic signed [15:0] exp,
                              input logic signed [15:0] act);
        if (act !== exp) begin
            $display("mismatch %0s expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input logic [8*24-1:0] name,
                              input logic [snd_pkg::ROM_ADDR_BITS-1:0] exp,
                              input logic [snd_pkg::ROM_ADDR_BITS-1:0] act);
        if (act !== exp) begin
            $display("mismatch %0s expected %05h actual %05h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input logic [8*24-1:0] name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %0s expected %0b actual %0b", name, exp, act);
            errors++;
        end
    endtask

    function automatic snd_pkg::snd_region_e region_of(input logic [15:0] adr, input logic we);
        if (adr[15:14] == 2'b00) return snd_pkg::region_rom;
        if (adr[15:12] == 4'h4) return snd_pkg::region_tone;
        if (adr[15:12] == 4'h7) return snd_pkg::region_shared;
        if (adr[15:13] == 3'b100) return snd_pkg::region_ram;
        if (adr[15:14] == 2'b11) return we ? snd_pkg::region_ctrl : snd_pkg::region_rom;
        return snd_pkg::region_none;
    endfunction

    // one classic cycle, held until ack
    task automatic bus_cycle(input logic we, input logic [15:0] adr, input logic [7:0] dat,
                             output logic [7:0] rdata, output logic [16:0] seen_addr);
        tick();  // stb stays low over one edge between cycles
        wb_cyc    = 1'b1;
        wb_stb    = 1'b1;
        wb_we     = we;
        wb_adr    = adr;
        wb_dat_w  = dat;
        seen_addr = '0;
        do begin
            tick();
            if (rom_cs) seen_addr = rom_addr;
        end while (!wb_ack);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // counts pulses consumed at edges still ahead
    task automatic wait_samples(input int n);
        repeat (n) begin
            while (!sample) tick();
            tick();
        end
    endtask

    task automatic load_cases();
        int               fd;
        int               n;
        logic [8*24-1:0]  tok;
        logic [8*8-1:0]   op_s;
        logic [8*128-1:0] skip;
        logic [15:0]      a, e;
        logic [7:0]       d;
        logic [10:0]      p;
        n_cases = 0;
        fd = $fopen("dv/snd_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/snd_cases.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1) break;
            if (tok == "#") begin
                n = $fgets(skip, fd);  // column note
            end else begin
                n = $fscanf(fd, "%s %h %h %h %h", op_s, a, d, p, e);
                if (n != 5) begin
                    $display("case line %0s is malformed", tok);
                    errors++;
                    break;
                end
                case (op_s)
                    "rd":     c_op[n_cases] = rd;
                    "wr":     c_op[n_cases] = wr;
                    "vbl":    c_op[n_cases] = vbl;
                    "irqchk": c_op[n_cases] = irqchk;
                    "mix":    c_op[n_cases] = mix;
                    default: begin
                        $display("case %0s has an unknown operation", tok);
                        errors++;
                    end
                endcase
                c_name[n_cases] = tok;
                c_adr[n_cases]  = a;
                c_dat[n_cases]  = d;
                c_pcm[n_cases]  = p;
                c_exp[n_cases]  = e;
                n_cases++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_case(input int i);
        logic [7:0]  rdata;
        logic [16:0] raddr;
        logic [snd_pkg::ROM_BANK_BITS-1:0] exp_bank;
        snd_pkg::snd_region_e reg_e;
        int we_before;
        int shared_before;
        int busy_before;
        int stalls_before;
        int errs_before;
        errs_before   = errors;
        we_before     = ram_we_cnt;
        shared_before = shared_cnt;
        busy_before   = busy_cnt;
        stalls_before = rom_stalls;
        reg_e         = region_of(c_adr[i], c_op[i] == wr);
        case (c_op[i])
            rd, wr: begin
                bus_cycle(c_op[i] == wr, c_adr[i], c_dat[i], rdata, raddr);
                if (c_op[i] == rd) check_byte(c_name[i], c_exp[i][7:0], rdata);
                if (reg_e == snd_pkg::region_rom) begin
                    exp_bank = (c_adr[i][15:14] == 2'b11) ? '0 : cur_bank;  // high window
                    check_addr(c_name[i], {exp_bank, c_adr[i][13:0]}, raddr);
                end
                check_bit(c_name[i], reg_e == snd_pkg::region_ram && c_op[i] == wr,
                          ram_we_cnt != we_before);
                check_bit(c_name[i], reg_e == snd_pkg::region_shared,
                          shared_cnt != shared_before);
                check_bit(c_name[i], rom_stalls != stalls_before, busy_cnt != busy_before);
                if (reg_e == snd_pkg::region_ctrl && c_adr[i][13:12] == 2'b00) begin
                    cur_bank = c_dat[i][6:4];
                end
            end
            vbl: begin
                lvbl = c_dat[i][0];
                repeat (3) tick();
                check_bit(c_name[i], c_exp[i][0], irq_n);
            end
            irqchk: check_bit(c_name[i], c_exp[i][0], irq_n);
            mix: begin
                pcm_snd = c_pcm[i];
                wait_samples(2);
                tick();  // mixer register
                case (c_adr[i][1:0])
                    2'd0:    check_word(c_name[i], c_exp[i], left);
                    2'd1:    check_word(c_name[i], c_exp[i], right);
                    default: check_bit(c_name[i], c_exp[i][0], peak);
                endcase
            end
            default: ;
        endcase
        if (errors == errs_before) begin
            n_pass++;
            $display("pass %0s", c_name[i]);
        end else begin
            n_fail++;
            $display("fail %0s", c_name[i]);
        end
    endtask

    initial begin
        seed     = 32'h9af11914;
        srst_n   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 16'h0000;
        wb_dat_w = 8'h00;
        lvbl     = 1'b1;
        pcm_snd  = 11'sd0;
        cur_bank = '0;
        errors   = 0;
        n_pass   = 0;
        n_fail   = 0;
        for (int a = 0; a < 8192; a++) begin
            ram_mem[a] = 8'(a) ^ 8'(a >> 8);
        end
        load_cases();
        cases_loaded = 1'b1;
        repeat (16) @(posedge clk);
        #1 srst_n = 1'b1;
        tick();
        for (int i = 0; i < n_cases; i++) run_case(i);
        $display("cases %0d passed %0d failed %0d errors %0d", n_cases, n_pass, n_fail, errors);
        if (errors == 0 && n_cases > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* dv/snd_cases.txt */
# name op addr data pcm expected, all hex; expected is read byte, irq_n, sample or peak
# mix: addr 0 checks left, 1 right, 2 peak; vbl: data is the lvbl level
rom_bank0     rd     1234 00 000 0034
bank_set5     wr     c000 50 000 0000
rom_bank5     rd     1234 00 000 0031
rom_high      rd     d2a7 00 000 00a7
rom_bank5_top rd     3ffe 00 000 00fb
ram_wr        wr     8010 5a 000 0000
ram_rd        rd     8010 00 000 005a
shared_rd     rd     7123 00 000 0096
unmapped_rd   rd     a000 00 000 0000
irq_idle      irqchk 0000 00 000 0001
vbl_high      vbl    0000 01 000 0001
vbl_fall      vbl    0000 00 000 0000
irq_ack       wr     e000 00 000 0000
irq_clear     irqchk 0000 00 000 0001
vbl_high2     vbl    0000 01 000 0001
vbl_fall2     vbl    0000 00 000 0000
key_sel       wr     4000 00 000 0000
key_both      wr     4001 03 000 0000
key_rd        rd     4001 00 000 0003
level_sel     wr     4000 01 000 0000
level_40      wr     4001 40 000 0000
period_sel    wr     4000 02 000 0000
period_0      wr     4001 00 000 0000
mix_left      mix    0000 00 064 2064
mix_right     mix    0001 00 064 2064
mix_peak      mix    0002 00 064 0000
mix_neg_pcm   mix    0000 00 7f0 1ff0
period_2      wr     4001 02 000 0000
sq_pos        mix    0000 00 000 2000
sq_neg        mix    0000 00 000 e000
sq_pos2       mix    0000 00 000 2000
key_sel2      wr     4000 00 000 0000
key_left      wr     4001 01 000 0000
off_right     mix    0001 00 123 0123
period_sel2   wr     4000 02 000 0000
period_0b     wr     4001 00 000 0000
level_sel2    wr     4000 01 000 0000
level_max     wr     4001 7f 000 0000
sat_left      mix    0000 00 3ff 437f
sat_peak      mix    0002 00 3ff 0000
level_min     wr     4001 80 000 0000
sat_neg_left  mix    0000 00 400 bc00

/* sim.f */
hw/snd_pkg.sv
hw/snd_bus_decode.sv
hw/snd_tone_gen.sv
hw/snd_mixer.sv
hw/snd_top.sv
dv/snd_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sound subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module snd_tb \
    -Mdir obj_dir -o snd_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/snd_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    exit 1
fi
exit 0
